// ==== sim/execTestdata.txt ====
// func rs rt rd address pc, then expected value write pcNext taken (all hex)
// One instruction per line, results come back in this order
08 00 00 01 0001234 00400000 00001234 1 00400004 0
0f 00 00 02 000ffff 00400004 ffff0000 1 00400008 0
08 00 00 03 000fff6 00400008 fffffff6 1 0040000c 0
08 03 00 04 3ab0005 0040000c fffffffb 1 00400010 0
20 01 02 05 0000000 00400010 ffff1234 1 00400014 0
22 01 03 06 0000000 00400014 0000123e 1 00400018 0
24 05 01 07 0000000 00400018 00001234 1 0040001c 0
25 02 01 08 0000000 0040001c ffff1234 1 00400020 0
26 05 02 09 0000000 00400020 00001234 1 00400024 0
2a 03 01 0a 0000000 00400024 00000001 1 00400028 0
2a 01 03 0b 0000000 00400028 00000000 1 0040002c 0
08 01 00 00 0000001 0040002c 00001235 1 00400030 0
20 00 01 0c 0000000 00400030 00001234 1 00400034 0
02 00 00 00 3ffffff a0001000 00000000 0 affffffc 1
03 00 00 1f 0100040 00400038 00400040 1 00400100 1
20 1f 00 0d 0000000 0040003c 00400040 1 00400040 0
04 01 07 00 0000010 00400100 00000000 0 00400140 1
04 01 02 00 0000010 00400104 00000000 0 00400108 0
05 01 02 00 000fffc 00400200 00000000 0 004001f0 1
05 01 07 00 000fffc 00400204 00000000 0 00400208 0
11 03 00 00 0000008 00400300 00000000 0 00400304 0
11 00 00 00 0000008 00400304 00000000 0 00400324 1
11 01 00 00 000ffff 00400308 00000000 0 00400304 1
07 03 00 00 0000004 00400400 00000000 0 00400404 0
07 00 00 00 0000004 00400404 00000000 0 00400408 0
07 01 00 00 0000004 00400408 00000000 0 00400418 1
06 03 00 00 000fff0 00400500 00000000 0 004004c0 1
06 00 00 00 0000002 00400504 00000000 0 0040050c 1
06 01 00 00 0000002 00400508 00000000 0 0040050c 0
10 03 00 00 0000003 00400600 00000000 0 0040060c 1
10 00 00 00 0000003 00400604 00000000 0 00400608 0
10 01 00 00 0000003 00400608 00000000 0 0040060c 0
13 01 00 1f 0000040 00400700 00400708 1 00400800 1
20 1f 00 0e 0000000 00400704 00400708 1 00400708 0
13 03 00 1f 0000040 00400710 00400718 1 00400714 0
20 1f 00 0f 0000000 00400714 00400718 1 00400718 0
12 03 00 1f 000fff8 00400800 00400808 1 004007e0 1
12 01 00 1f 0000010 00400810 00400818 1 00400814 0
20 1f 00 10 0000000 00400820 00400818 1 00400824 0

// ==== sources.f ====
source/isaPkg.sv
source/dataPkg.sv
source/regFile.sv
source/branch.sv
source/alu.sv
source/execStage.sv
sim/execChecker.sv
sim/execStageTb.sv

// ==== Makefile ====
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= execStageTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation completed successfully
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Runs from the project root so the data file path resolves
run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/execStageTb.sv ====
module execStageTb
    import dataPkg::*;
    import isaPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int vecCount    = 39;
    localparam int fieldCount  = 10;
    localparam int resetCycles = 16;
    localparam int cycleLimit  = vecCount * 20 + 100;

    logic        clk = 1'b0;
    logic        rstN;
    logic        inValid;
    logic        inReady;
    opFunc_e     inFunc;
    regIdx_t     inRs;
    regIdx_t     inRt;
    regIdx_t     inRd;
    addrField_t  inAddress;
    word_t       inPc;
    logic        resValid;
    logic        resReady;
    word_t       resValue;
    regIdx_t     resDest;
    logic        resWrite;
    word_t       resPcNext;
    logic        resTaken;
    logic        inFire = 1'b0;
    int          checkedCount;
    int          mismatchCount;
    int          stallCount;
    int          extraCount;
    int          cycleCount;
    logic [31:0] lfsrState = 32'h6e44;
    logic [31:0] vecMem [vecCount*fieldCount];

    always #50 clk = ~clk;

    execStage u_dut (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inReady   (inReady),
        .inFunc    (inFunc),
        .inRs      (inRs),
        .inRt      (inRt),
        .inRd      (inRd),
        .inAddress (inAddress),
        .inPc      (inPc),
        .resValid  (resValid),
        .resReady  (resReady),
        .resValue  (resValue),
        .resDest   (resDest),
        .resWrite  (resWrite),
        .resPcNext (resPcNext),
        .resTaken  (resTaken)
    );

    execChecker #(.vecCount(vecCount)) u_checker (
        .clk           (clk),
        .rstN          (rstN),
        .inReady       (inReady),
        .resValid      (resValid),
        .resReady      (resReady),
        .resValue      (resValue),
        .resDest       (resDest),
        .resWrite      (resWrite),
        .resPcNext     (resPcNext),
        .resTaken      (resTaken),
        .checkedCount  (checkedCount),
        .mismatchCount (mismatchCount),
        .stallCount    (stallCount),
        .extraCount    (extraCount)
    );

    // --------------------
    // Random source
    // --------------------
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic drawBit(output logic bitOut);
        lfsrState = lfsrNext(lfsrState);
        bitOut    = lfsrState[0];
    endtask

    // High about one time in four
    task automatic drawQuarter(output logic hit);
        logic b0;
        logic b1;
        drawBit(b0);
        drawBit(b1);
        hit = b0 && b1;
    endtask

    task automatic presentVector(input int idx);
        int b;
        b = idx * fieldCount;
        inFunc    = opFunc_e'(vecMem[b][5:0]);
        inRs      = vecMem[b+1][4:0];
        inRt      = vecMem[b+2][4:0];
        inRd      = vecMem[b+3][4:0];
        inAddress = vecMem[b+4][25:0];
        inPc      = vecMem[b+5];
        inValid   = 1'b1;
    endtask

    // Handshake seen mid-cycle completes on the following edge
    always @(negedge clk)
    begin
        inFire = inValid && inReady;
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout after %0d cycles with %0d of %0d results checked",
                     cycleCount, checkedCount, vecCount);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial
    begin
        logic idle;
        int   nextVec;
        int   errors;
        $readmemh("sim/execTestdata.txt", vecMem);
        rstN      = 1'b0;
        inValid   = 1'b0;
        inFunc    = opAdd;
        inRs      = '0;
        inRt      = '0;
        inRd      = '0;
        inAddress = '0;
        inPc      = '0;
        resReady  = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 rstN = 1'b1;
        nextVec = 0;
        while (checkedCount < vecCount)
        begin
            @(posedge clk);
            #1;
            if (inFire)
            begin
                inValid = 1'b0;   // Accepted on the edge just passed
                nextVec++;
            end
            drawQuarter(idle);
            resReady = !idle;
            if (!inValid && (nextVec < vecCount))
            begin
                drawQuarter(idle);   // Occasional gap on the input
                if (!idle)
                begin
                    presentVector(nextVec);
                end
            end
        end
        resReady = 1'b1;
        repeat (5) @(posedge clk);   // Leaves room to spot extra results
        errors = mismatchCount + stallCount + extraCount;
        $display("Checked %0d of %0d results with %0d mismatches, %0d stall errors, %0d extra",
                 checkedCount, vecCount, mismatchCount, stallCount, extraCount);
        if (errors == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim/execChecker.sv ====
module execChecker
    import dataPkg::*;
    import isaPkg::*;
#(
    parameter int vecCount = 1
)
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    inReady,
    input  logic    resValid,
    input  logic    resReady,
    input  word_t   resValue,
    input  regIdx_t resDest,
    input  logic    resWrite,
    input  word_t   resPcNext,
    input  logic    resTaken,
    output int      checkedCount,
    output int      mismatchCount,
    output int      stallCount,
    output int      extraCount
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int fieldCount = 10;

    logic [31:0] vecMem [vecCount*fieldCount];
    logic [71:0] outputsNow;
    logic [71:0] heldOutputs;
    logic        stalled;
    logic        expReady;

    initial
    begin
        $readmemh("sim/execTestdata.txt", vecMem);
    end

    assign outputsNow = {resValid, resValue, resDest, resWrite, resPcNext, resTaken};

    task automatic compareField(input int idx, input string name,
                                input word_t got, input word_t exp);
        if (got !== exp)
        begin
            mismatchCount++;
            $display("mismatch at %0t: vector %0d %s got %h expected %h",
                     $time, idx, name, got, exp);
        end
    endtask

    // Columns 3 and 6..9 hold rd and the expected outputs
    task automatic compareResult(input int idx);
        int b;
        b = idx * fieldCount;
        compareField(idx, "resValue", resValue, vecMem[b+6]);
        compareField(idx, "resDest", word_t'(resDest), vecMem[b+3]);
        compareField(idx, "resWrite", word_t'(resWrite), vecMem[b+7]);
        compareField(idx, "resPcNext", resPcNext, vecMem[b+8]);
        compareField(idx, "resTaken", word_t'(resTaken), vecMem[b+9]);
    endtask

    // --------------------
    // Output monitor
    // --------------------
    // A transfer seen at mid-cycle completes on the next rising edge
    always @(negedge clk)
    begin
        if (!rstN)
        begin
            checkedCount  = 0;
            mismatchCount = 0;
            stallCount    = 0;
            extraCount    = 0;
            stalled       = 1'b0;
        end
        else
        begin
            // Input side may only be blocked by a held result
            expReady = !(resValid && !resReady);
            if (inReady !== expReady)
            begin
                mismatchCount++;
                $display("mismatch at %0t: inReady got %b expected %b",
                         $time, inReady, expReady);
            end
            if (stalled && (outputsNow !== heldOutputs))
            begin
                stallCount++;
                $display("Result outputs changed while stalled at %0t", $time);
            end
            if (resValid && resReady)
            begin
                if (checkedCount >= vecCount)
                begin
                    extraCount++;
                    $display("Unexpected result transfer beyond the last vector at %0t",
                             $time);
                end
                else
                begin
                    compareResult(checkedCount);
                    checkedCount++;
                end
            end
            stalled     = resValid && !resReady;   // Must hold until drained
            heldOutputs = outputsNow;
        end
    end

endmodule

// ==== source/execStage.sv ====
module execStage
    import dataPkg::*;
    import isaPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    // Decoded instruction in
    input  logic       inValid,
    output logic       inReady,
    input  opFunc_e    inFunc,
    input  regIdx_t    inRs,
    input  regIdx_t    inRt,
    input  regIdx_t    inRd,
    input  addrField_t inAddress,
    input  word_t      inPc,
    // Result out
    output logic       resValid,
    input  logic       resReady,
    output word_t      resValue,
    output regIdx_t    resDest,
    output logic       resWrite,
    output word_t      resPcNext,
    output logic       resTaken
);

    logic  accept;
    logic  isBranch;
    logic  isLink;
    logic  isAluOp;
    logic  writes;
    word_t opA;
    word_t opB;
    word_t aluResult;
    word_t branchPc;
    word_t retAddr;
    logic  branchTaken;
    word_t wbValue;
    word_t nextPc;

    // --------------------
    // Handshake
    // --------------------
    assign inReady = !resValid || resReady;   // Empty or draining now
    assign accept  = inValid && inReady;

    // --------------------
    // Function decode
    // --------------------
    always_comb
    begin
        isBranch = 1'b0;
        isLink   = 1'b0;
        isAluOp  = 1'b0;
        case (inFunc)
            opAdd, opSub, opAnd, opOr, opXor, opSlt, opAddi, opLui:
                isAluOp = 1'b1;
            opJal, opBgezal, opBltzal:
            begin
                isBranch = 1'b1;
                isLink   = 1'b1;   // Writes PC+8 even if not taken
            end
            opJ, opBeq, opBne, opBgez, opBgtz, opBlez, opBltz:
                isBranch = 1'b1;
            default:
                isBranch = 1'b0;
        endcase
    end

    assign writes = isAluOp || isLink;

    regFile u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rdIdxA  (inRs),
        .rdIdxB  (inRt),
        .rdDataA (opA),
        .rdDataB (opB),
        .wrEn    (accept && writes),
        .wrIdx   (inRd),
        .wrData  (wbValue)
    );

    branch u_branch (
        .enable  (isBranch),
        .pcIn    (inPc),
        .a       (opA),
        .b       (opB),
        .address (inAddress),
        .func    (inFunc),
        .pcOut   (branchPc),
        .ret     (retAddr),
        .taken   (branchTaken)
    );

    alu u_alu (
        .a      (opA),
        .b      (opB),
        .imm    (inAddress),
        .func   (inFunc),
        .result (aluResult)
    );

    assign wbValue = isLink ? retAddr : aluResult;
    // Not-taken branches fall through like everything else
    assign nextPc  = branchTaken ? branchPc : inPc + word_t'(pcStep);

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            resValid <= 1'b0;
            resWrite <= 1'b0;
            resTaken <= 1'b0;
        end
        else if (accept)
        begin
            resValid <= 1'b1;
            resWrite <= writes;
            resTaken <= branchTaken;
        end
        else if (resReady)
        begin
            resValid <= 1'b0;   // Drained, flags kept until next load
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            resValue  <= wbValue;
            resDest   <= inRd;
            resPcNext <= nextPc;
        end
    end

endmodule

// ==== source/alu.sv ====
module alu
    import dataPkg::*;
    import isaPkg::*;
(
    input  word_t      a,
    input  word_t      b,
    input  addrField_t imm,
    input  opFunc_e    func,
    output word_t      result
);

    word_t immExt;
    word_t immUpper;
    logic  lessThan;

    // --------------------
    // Immediate forms
    // --------------------
    assign immExt   = word_t'($signed(imm[immWidth-1:0]));   // ADDI operand
    assign immUpper = {imm[immWidth-1:0], {(wordWidth-immWidth){1'b0}}};

    assign lessThan = ($signed(a) < $signed(b));

    // --------------------
    // Operation select
    // --------------------
    always_comb
    begin
        case (func)
            opAdd:
                result = a + b;
            opSub:
                result = a - b;
            opAnd:
                result = a & b;
            opOr:
                result = a | b;
            opXor:
                result = a ^ b;
            opSlt:
                result = word_t'(lessThan);
            opAddi:
                result = a + immExt;
            opLui:
                result = immUpper;   // Low half cleared
            default:
                result = '0;         // Branches and unknown codes
        endcase
    end

endmodule

// ==== source/branch.sv ====
module branch
    import dataPkg::*;
    import isaPkg::*;
(
    input  logic       enable,    // Only set for branch codes
    input  word_t      pcIn,
    input  word_t      a,
    input  word_t      b,
    input  addrField_t address,
    input  opFunc_e    func,
    output word_t      pcOut,
    output word_t      ret,
    output logic       taken
);

    word_t jumpTarget;
    word_t branchTarget;
    word_t offset;
    logic  isJump;
    logic  condMet;

    // Region jump keeps the top four PC bits
    assign jumpTarget = {pcIn[wordWidth-1:wordWidth-4], address, 2'b00};

    // Sign extended word offset, may be negative
    assign offset       = word_t'($signed(address[immWidth-1:0])) << targetShift;
    assign branchTarget = pcIn + offset;

    assign isJump = (func == opJ) || (func == opJal);

    // --------------------
    // Branch conditions
    // --------------------
    always_comb
    begin
        condMet = 1'b0;
        case (func)
            opBeq:
                condMet = (a == b);
            opBne:
                condMet = (a != b);
            opBgez,
            opBgezal:
                condMet = ($signed(a) >= 0);
            opBgtz:
                condMet = ($signed(a) > 0);
            opBlez:
                condMet = ($signed(a) <= 0);
            opBltz,
            opBltzal:
                condMet = ($signed(a) < 0);
            default:
                condMet = 1'b0;   // Jumps and non-branch codes
        endcase
    end

    // --------------------
    // Next PC
    // --------------------
    always_comb
    begin
        pcOut = pcIn;
        taken = 1'b0;
        if (enable)
        begin
            if (isJump)
            begin
                pcOut = jumpTarget;
                taken = 1'b1;
            end
            else if (condMet)
            begin
                pcOut = branchTarget;
                taken = 1'b1;
            end
        end
    end

    // Link value whether or not the branch is taken
    assign ret = pcIn + word_t'(linkPcOffset);

endmodule

// ==== source/regFile.sv ====
module regFile
    import dataPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  regIdx_t rdIdxA,
    input  regIdx_t rdIdxB,
    output word_t   rdDataA,
    output word_t   rdDataB,
    input  logic    wrEn,
    input  regIdx_t wrIdx,
    input  word_t   wrData
);

    word_t regs [regCount];

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < regCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrEn && (wrIdx != '0))   // r0 stays zero
        begin
            regs[wrIdx] <= wrData;
        end
    end

    // --------------------
    // Read ports
    // --------------------
    // Combinational, so a write on the accepting edge is seen
    // by the next instruction
    assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
    assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

endmodule

// ==== source/dataPkg.sv ====
package dataPkg;

    localparam int wordWidth   = 32;
    localparam int regCount    = 32;
    localparam int regIdxWidth = $clog2(regCount);

    // Operands, results and PC values
    typedef logic [wordWidth-1:0] word_t;

    // Address/immediate field as it comes from the decoder
    typedef logic [isaPkg::addrFieldWidth-1:0] addrField_t;

    typedef logic [regIdxWidth-1:0] regIdx_t;

endpackage

// ==== source/isaPkg.sv ====
package isaPkg;

    // --------------------
    // Instruction fields
    // --------------------
    localparam int funcWidth      = 6;
    localparam int addrFieldWidth = 26;
    localparam int immWidth       = 16;   // Low part of the address field
    localparam int targetShift    = 2;    // Word aligned targets

    localparam int unsigned linkPcOffset = 8;   // PC to return address
    localparam int unsigned pcStep       = 4;   // Fall-through distance

    // --------------------
    // Function codes
    // --------------------
    typedef enum logic [funcWidth-1:0] {
        // Register and immediate ALU forms
        opAdd    = 6'h20,
        opSub    = 6'h22,
        opAnd    = 6'h24,
        opOr     = 6'h25,
        opXor    = 6'h26,
        opSlt    = 6'h2a,    // Signed compare
        opAddi   = 6'h08,
        opLui    = 6'h0f,
        // Jumps and branches
        opJ      = 6'h02,
        opJal    = 6'h03,
        opBeq    = 6'h04,
        opBne    = 6'h05,
        opBlez   = 6'h06,
        opBgtz   = 6'h07,
        opBltz   = 6'h10,
        opBgez   = 6'h11,
        opBltzal = 6'h12,
        opBgezal = 6'h13
    } opFunc_e;

endpackage
